//--- hw/iob2axi_pkg.sv
package iob2axi_pkg;

   // Burst length holds beats minus one
   localparam int axi_len_w = 8;

   typedef logic [axi_len_w-1:0] axi_len_t;
   typedef logic [1:0] axi_resp_t;

   localparam axi_resp_t axi_resp_okay = 2'd0;
   localparam axi_resp_t axi_resp_slverr = 2'd2;

   localparam logic [1:0] axi_burst_incr = 2'd1;

   // Normal non-cacheable modifiable, non-secure unprivileged data
   localparam logic [3:0] axi_cache_val = 4'd2;
   localparam logic [2:0] axi_prot_val = 3'd2;

   // Size code is log2 of the bytes per word
   function automatic logic [2:0] axi_size(input int data_w);
      return 3'($clog2(data_w / 8));
   endfunction

endpackage

//--- hw/iob2axi_rd.sv
`timescale 1ns/100ps

module iob2axi_rd import iob2axi_pkg::*; #(
   parameter int ADDR_W = 16,
   parameter int DATA_W = 32
) (
   input  logic              clk,
   input  logic              rst,
   // Control
   input  axi_len_t          length,
   output logic              ready,
   output logic              error,
   // Native slave side
   input  logic              s_valid,
   input  logic [ADDR_W-1:0] s_addr,
   output logic [DATA_W-1:0] s_rdata,
   output logic              s_ready,
   // AXI4 read address
   output logic              m_axi_arid,
   output logic [ADDR_W-1:0] m_axi_araddr,
   output axi_len_t          m_axi_arlen,
   output logic [2:0]        m_axi_arsize,
   output logic [1:0]        m_axi_arburst,
   output logic              m_axi_arlock,
   output logic [3:0]        m_axi_arcache,
   output logic [2:0]        m_axi_arprot,
   output logic [3:0]        m_axi_arqos,
   output logic              m_axi_arvalid,
   input  logic              m_axi_arready,
   // AXI4 read data
   input  logic              m_axi_rvalid,
   input  logic [DATA_W-1:0] m_axi_rdata,
   input  axi_resp_t         m_axi_rresp,
   input  logic              m_axi_rlast,
   output logic              m_axi_rready
);

   localparam logic ADDR_HS = 1'b0;
   localparam logic READ = 1'b1;

   logic              state;
   logic [ADDR_W-1:0] addr_reg;
   axi_len_t          length_reg;
   axi_len_t          counter;
   logic              slverr_seen;
   logic              ar_hs;
   logic              r_hs;
   logic              last_beat;
   logic              beat_err;

   // Fixed burst attributes
   assign m_axi_arid = 1'b0;
   assign m_axi_arsize = axi_size(DATA_W);
   assign m_axi_arburst = axi_burst_incr;
   assign m_axi_arlock = 1'b0;
   assign m_axi_arcache = axi_cache_val;
   assign m_axi_arprot = axi_prot_val;
   assign m_axi_arqos = 4'd0;

   // Request goes straight out while idle, latched copy afterwards
   assign m_axi_arvalid = (state == ADDR_HS) & s_valid & ready;
   assign m_axi_araddr = (state == ADDR_HS) ? s_addr : addr_reg;
   assign m_axi_arlen = (state == ADDR_HS) ? length : length_reg;

   // Native requester throttles the read data channel
   assign m_axi_rready = (state == READ) & s_valid;

   assign ar_hs = m_axi_arvalid & m_axi_arready;
   assign r_hs = m_axi_rvalid & m_axi_rready;
   assign last_beat = r_hs & (counter == length_reg);
   assign beat_err = (m_axi_rresp == axi_resp_slverr);

   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         state <= ADDR_HS;
         ready <= 1'b1;
         error <= 1'b0;
         s_ready <= 1'b0;
         counter <= '0;
         slverr_seen <= 1'b0;
         length_reg <= '0;
      end else begin
         // Ready comes back one cycle after the return to idle
         ready <= (state == ADDR_HS) & ~ar_hs;
         s_ready <= r_hs;
         if (state == ADDR_HS) begin
            counter <= '0;
            slverr_seen <= 1'b0;
            if (ar_hs) begin
               length_reg <= length;
               state <= READ;
            end
         end else begin
            if (r_hs) begin
               counter <= counter + 1'b1;
               slverr_seen <= slverr_seen | beat_err;
            end
            // Final counted beat must carry rlast
            if (last_beat) begin
               error <= ~m_axi_rlast | slverr_seen | beat_err;
               state <= ADDR_HS;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (ar_hs) begin
         addr_reg <= s_addr;
      end
      if (r_hs) begin
         s_rdata <= m_axi_rdata;
      end
   end

endmodule

//--- hw/iob2axi_wr.sv
`timescale 1ns/100ps

module iob2axi_wr import iob2axi_pkg::*; #(
   parameter int ADDR_W = 16,
   parameter int DATA_W = 32
) (
   input  logic                clk,
   input  logic                rst,
   // Control
   input  axi_len_t            length,
   output logic                ready,
   output logic                error,
   // Native slave side
   input  logic                s_valid,
   input  logic [ADDR_W-1:0]   s_addr,
   input  logic [DATA_W-1:0]   s_wdata,
   output logic                s_ready,
   // AXI4 write address
   output logic                m_axi_awid,
   output logic [ADDR_W-1:0]   m_axi_awaddr,
   output axi_len_t            m_axi_awlen,
   output logic [2:0]          m_axi_awsize,
   output logic [1:0]          m_axi_awburst,
   output logic                m_axi_awlock,
   output logic [3:0]          m_axi_awcache,
   output logic [2:0]          m_axi_awprot,
   output logic [3:0]          m_axi_awqos,
   output logic                m_axi_awvalid,
   input  logic                m_axi_awready,
   // AXI4 write data
   output logic [DATA_W-1:0]   m_axi_wdata,
   output logic [DATA_W/8-1:0] m_axi_wstrb,
   output logic                m_axi_wlast,
   output logic                m_axi_wvalid,
   input  logic                m_axi_wready,
   // AXI4 write response
   input  logic                m_axi_bvalid,
   input  axi_resp_t           m_axi_bresp,
   output logic                m_axi_bready
);

   localparam logic [1:0] ADDR_HS = 2'd0;
   localparam logic [1:0] WRITE = 2'd1;
   localparam logic [1:0] RESP = 2'd2;

   logic [1:0]        state;
   logic [ADDR_W-1:0] addr_reg;
   axi_len_t          length_reg;
   axi_len_t          counter;
   logic              aw_hs;
   logic              w_hs;

   assign m_axi_awid = 1'b0;
   assign m_axi_awsize = axi_size(DATA_W);
   assign m_axi_awburst = axi_burst_incr;
   assign m_axi_awlock = 1'b0;
   assign m_axi_awcache = axi_cache_val;
   assign m_axi_awprot = axi_prot_val;
   assign m_axi_awqos = 4'd0;

   assign m_axi_awvalid = (state == ADDR_HS) & s_valid & ready;
   assign m_axi_awaddr = (state == ADDR_HS) ? s_addr : addr_reg;
   assign m_axi_awlen = (state == ADDR_HS) ? length : length_reg;

   // Native word passes straight through, full strobes only
   assign m_axi_wdata = s_wdata;
   assign m_axi_wstrb = {(DATA_W / 8){1'b1}};
   assign m_axi_wvalid = (state == WRITE) & s_valid;
   assign m_axi_wlast = (state == WRITE) & (counter == length_reg);
   assign m_axi_bready = (state == RESP);

   assign aw_hs = m_axi_awvalid & m_axi_awready;
   assign w_hs = m_axi_wvalid & m_axi_wready;

   // Ack is the data handshake itself
   assign s_ready = w_hs;

   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         state <= ADDR_HS;
         ready <= 1'b1;
         error <= 1'b0;
         counter <= '0;
         length_reg <= '0;
      end else begin
         ready <= (state == ADDR_HS) & ~aw_hs;
         case (state)
            ADDR_HS: begin
               counter <= '0;
               if (aw_hs) begin
                  length_reg <= length;
                  state <= WRITE;
               end
            end
            WRITE: begin
               if (w_hs) begin
                  counter <= counter + 1'b1;
                  if (m_axi_wlast) begin
                     state <= RESP;
                  end
               end
            end
            RESP: begin
               if (m_axi_bvalid) begin
                  error <= (m_axi_bresp != axi_resp_okay);
                  state <= ADDR_HS;
               end
            end
            default: state <= ADDR_HS;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (aw_hs) begin
         addr_reg <= s_addr;
      end
   end

endmodule

//--- hw/axi_ram.sv
`timescale 1ns/100ps

module axi_ram import iob2axi_pkg::*; #(
   parameter int ADDR_W = 16,
   parameter int DATA_W = 32,
   parameter int MEM_DEPTH_LOG = 8
) (
   input  logic                clk,
   input  logic                rst,
   // Read address
   input  logic                m_axi_arid,
   input  logic [ADDR_W-1:0]   m_axi_araddr,
   input  axi_len_t            m_axi_arlen,
   input  logic [2:0]          m_axi_arsize,
   input  logic [1:0]          m_axi_arburst,
   input  logic                m_axi_arlock,
   input  logic [3:0]          m_axi_arcache,
   input  logic [2:0]          m_axi_arprot,
   input  logic [3:0]          m_axi_arqos,
   input  logic                m_axi_arvalid,
   output logic                m_axi_arready,
   // Read data
   output logic                m_axi_rvalid,
   output logic [DATA_W-1:0]   m_axi_rdata,
   output axi_resp_t           m_axi_rresp,
   output logic                m_axi_rlast,
   input  logic                m_axi_rready,
   // Write address
   input  logic                m_axi_awid,
   input  logic [ADDR_W-1:0]   m_axi_awaddr,
   input  axi_len_t            m_axi_awlen,
   input  logic [2:0]          m_axi_awsize,
   input  logic [1:0]          m_axi_awburst,
   input  logic                m_axi_awlock,
   input  logic [3:0]          m_axi_awcache,
   input  logic [2:0]          m_axi_awprot,
   input  logic [3:0]          m_axi_awqos,
   input  logic                m_axi_awvalid,
   output logic                m_axi_awready,
   // Write data and response
   input  logic [DATA_W-1:0]   m_axi_wdata,
   input  logic [DATA_W/8-1:0] m_axi_wstrb,
   input  logic                m_axi_wlast,
   input  logic                m_axi_wvalid,
   output logic                m_axi_wready,
   output logic                m_axi_bvalid,
   output axi_resp_t           m_axi_bresp,
   input  logic                m_axi_bready
);

   localparam int OFF = $clog2(DATA_W / 8);
   localparam int WORD_W = ADDR_W - OFF;

   localparam logic [1:0] IDLE = 2'd0;
   localparam logic [1:0] RD = 2'd1;
   localparam logic [1:0] WR = 2'd2;
   localparam logic [1:0] RESP = 2'd3;

   logic [DATA_W-1:0] mem [2**MEM_DEPTH_LOG];

   logic [1:0]        state;
   logic [WORD_W-1:0] waddr;
   logic [WORD_W-1:0] rd_idx;
   axi_len_t          beats;
   logic              burst_ok;
   logic              wr_err;
   logic              ar_ok;
   logic              aw_ok;
   logic              ar_hs;
   logic              r_hs;
   logic              aw_hs;
   logic              w_hs;
   logic              rd_load;
   logic              rd_ok;
   logic              wr_ok;
   logic              beat_err;

   function automatic logic in_range(input logic [WORD_W-1:0] idx);
      return (idx >> MEM_DEPTH_LOG) == '0;
   endfunction

   // Only plain full-width INCR data bursts with ID zero are served
   function automatic logic attr_ok(input logic id, input logic [1:0] burst,
                                    input logic [2:0] size, input logic lock,
                                    input logic [3:0] cache, input logic [2:0] prot,
                                    input logic [3:0] qos);
      return !id && !lock && (burst == axi_burst_incr) && (size == axi_size(DATA_W))
             && cache[1] && !prot[2] && (qos == 4'd0);
   endfunction

   assign ar_ok = attr_ok(m_axi_arid, m_axi_arburst, m_axi_arsize, m_axi_arlock,
                          m_axi_arcache, m_axi_arprot, m_axi_arqos);
   assign aw_ok = attr_ok(m_axi_awid, m_axi_awburst, m_axi_awsize, m_axi_awlock,
                          m_axi_awcache, m_axi_awprot, m_axi_awqos);

   // Pending AW wins over AR
   assign m_axi_awready = (state == IDLE);
   assign m_axi_arready = (state == IDLE) & ~m_axi_awvalid;
   assign m_axi_wready = (state == WR);

   assign ar_hs = m_axi_arvalid & m_axi_arready;
   assign r_hs = m_axi_rvalid & m_axi_rready;
   assign aw_hs = m_axi_awvalid & m_axi_awready;
   assign w_hs = m_axi_wvalid & m_axi_wready;

   // Next read word is the burst start or the one after the current beat
   assign rd_idx = (state == IDLE) ? m_axi_araddr[ADDR_W-1:OFF] : waddr + 1'b1;
   assign rd_load = ar_hs | (r_hs & ~m_axi_rlast);
   assign rd_ok = ((state == IDLE) ? ar_ok : burst_ok) & in_range(rd_idx);

   assign wr_ok = burst_ok & in_range(waddr);
   // A wlast that disagrees with awlen also fails the burst
   assign beat_err = ~wr_ok | (m_axi_wlast != (beats == '0));

   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         state <= IDLE;
         waddr <= '0;
         beats <= '0;
         burst_ok <= 1'b0;
         wr_err <= 1'b0;
         m_axi_rvalid <= 1'b0;
         m_axi_rlast <= 1'b0;
         m_axi_bvalid <= 1'b0;
         m_axi_bresp <= axi_resp_okay;
      end else begin
         case (state)
            IDLE: begin
               if (aw_hs) begin
                  waddr <= m_axi_awaddr[ADDR_W-1:OFF];
                  beats <= m_axi_awlen;
                  burst_ok <= aw_ok;
                  wr_err <= 1'b0;
                  state <= WR;
               end else if (ar_hs) begin
                  waddr <= rd_idx;
                  beats <= m_axi_arlen;
                  burst_ok <= ar_ok;
                  m_axi_rvalid <= 1'b1;
                  m_axi_rlast <= (m_axi_arlen == '0);
                  state <= RD;
               end
            end
            RD: begin
               if (r_hs) begin
                  if (m_axi_rlast) begin
                     m_axi_rvalid <= 1'b0;
                     state <= IDLE;
                  end else begin
                     waddr <= rd_idx;
                     beats <= beats - 1'b1;
                     m_axi_rlast <= (beats == 8'd1);
                  end
               end
            end
            WR: begin
               if (w_hs) begin
                  waddr <= waddr + 1'b1;
                  beats <= beats - 1'b1;
                  wr_err <= wr_err | beat_err;
                  if (m_axi_wlast) begin
                     m_axi_bvalid <= 1'b1;
                     m_axi_bresp <= (wr_err | beat_err) ? axi_resp_slverr : axi_resp_okay;
                     state <= RESP;
                  end
               end
            end
            default: begin
               if (m_axi_bready) begin
                  m_axi_bvalid <= 1'b0;
                  state <= IDLE;
               end
            end
         endcase
      end
   end

   // Storage and read data path
   always_ff @(posedge clk) begin
      if (rd_load) begin
         m_axi_rdata <= rd_ok ? mem[rd_idx[MEM_DEPTH_LOG-1:0]] : '0;
         m_axi_rresp <= rd_ok ? axi_resp_okay : axi_resp_slverr;
      end
      if (w_hs && wr_ok) begin
         for (int b = 0; b < DATA_W / 8; b++) begin
            if (m_axi_wstrb[b]) begin
               mem[waddr[MEM_DEPTH_LOG-1:0]][8*b +: 8] <= m_axi_wdata[8*b +: 8];
            end
         end
      end
   end

endmodule

//--- hw/iob2axi_top.sv
`timescale 1ns/100ps

module iob2axi_top import iob2axi_pkg::*; #(
   parameter int ADDR_W = 16,
   parameter int DATA_W = 32,
   parameter int MEM_DEPTH_LOG = 8
) (
   input  logic              clk,
   input  logic              rst,
   // Native read port
   input  axi_len_t          rd_length,
   input  logic [ADDR_W-1:0] rd_addr,
   input  logic              rd_valid,
   output logic              rd_ready,
   output logic              rd_error,
   output logic [DATA_W-1:0] rd_data,
   output logic              rd_ack,
   // Native write port
   input  axi_len_t          wr_length,
   input  logic [ADDR_W-1:0] wr_addr,
   input  logic [DATA_W-1:0] wr_data,
   input  logic              wr_valid,
   output logic              wr_ready,
   output logic              wr_error,
   output logic              wr_ack
);

   // AXI read channels
   logic                m_axi_arid;
   logic [ADDR_W-1:0]   m_axi_araddr;
   axi_len_t            m_axi_arlen;
   logic [2:0]          m_axi_arsize;
   logic [1:0]          m_axi_arburst;
   logic                m_axi_arlock;
   logic [3:0]          m_axi_arcache;
   logic [2:0]          m_axi_arprot;
   logic [3:0]          m_axi_arqos;
   logic                m_axi_arvalid;
   logic                m_axi_arready;
   logic                m_axi_rvalid;
   logic [DATA_W-1:0]   m_axi_rdata;
   axi_resp_t           m_axi_rresp;
   logic                m_axi_rlast;
   logic                m_axi_rready;

   // AXI write channels
   logic                m_axi_awid;
   logic [ADDR_W-1:0]   m_axi_awaddr;
   axi_len_t            m_axi_awlen;
   logic [2:0]          m_axi_awsize;
   logic [1:0]          m_axi_awburst;
   logic                m_axi_awlock;
   logic [3:0]          m_axi_awcache;
   logic [2:0]          m_axi_awprot;
   logic [3:0]          m_axi_awqos;
   logic                m_axi_awvalid;
   logic                m_axi_awready;
   logic [DATA_W-1:0]   m_axi_wdata;
   logic [DATA_W/8-1:0] m_axi_wstrb;
   logic                m_axi_wlast;
   logic                m_axi_wvalid;
   logic                m_axi_wready;
   logic                m_axi_bvalid;
   axi_resp_t           m_axi_bresp;
   logic                m_axi_bready;

   // AXI ports match by name
   iob2axi_rd #(
      .ADDR_W(ADDR_W),
      .DATA_W(DATA_W)
   ) iob2axi_rd_inst (
      .length (rd_length),
      .ready  (rd_ready),
      .error  (rd_error),
      .s_valid(rd_valid),
      .s_addr (rd_addr),
      .s_rdata(rd_data),
      .s_ready(rd_ack),
      .*
   );

   iob2axi_wr #(
      .ADDR_W(ADDR_W),
      .DATA_W(DATA_W)
   ) iob2axi_wr_inst (
      .length (wr_length),
      .ready  (wr_ready),
      .error  (wr_error),
      .s_valid(wr_valid),
      .s_addr (wr_addr),
      .s_wdata(wr_data),
      .s_ready(wr_ack),
      .*
   );

   axi_ram #(
      .ADDR_W       (ADDR_W),
      .DATA_W       (DATA_W),
      .MEM_DEPTH_LOG(MEM_DEPTH_LOG)
   ) axi_ram_inst (
      .*
   );

endmodule

//--- test/iob2axi_chk.sv
`timescale 1ns/100ps

module iob2axi_chk import iob2axi_pkg::*; #(
   parameter int ADDR_W = 16,
   parameter int DATA_W = 32
) (
   input logic              clk,
   input logic              rst,
   input logic              rd_valid,
   input logic              rd_ack,
   input logic              wr_valid,
   input logic              wr_ack,
   input logic              m_axi_arvalid,
   input logic              m_axi_arready,
   input logic [ADDR_W-1:0] m_axi_araddr,
   input axi_len_t          m_axi_arlen,
   input logic              m_axi_awvalid,
   input logic              m_axi_awready,
   input logic [ADDR_W-1:0] m_axi_awaddr,
   input axi_len_t          m_axi_awlen,
   input logic              m_axi_rvalid,
   input logic              m_axi_rready,
   input logic [DATA_W-1:0] m_axi_rdata,
   input axi_resp_t         m_axi_rresp,
   input logic              m_axi_rlast
);

   // Read by the testbench
   int unsigned fail_count = 0;

   ar_stable: assert property (@(posedge clk) disable iff (rst)
      m_axi_arvalid && !m_axi_arready |=>
         m_axi_arvalid && $stable(m_axi_araddr) && $stable(m_axi_arlen))
      else begin
         fail_count++;
         $error("AR request changed before arready");
      end

   aw_stable: assert property (@(posedge clk) disable iff (rst)
      m_axi_awvalid && !m_axi_awready |=>
         m_axi_awvalid && $stable(m_axi_awaddr) && $stable(m_axi_awlen))
      else begin
         fail_count++;
         $error("AW request changed before awready");
      end

   // Memory must hold the beat while the master stalls
   r_stable: assert property (@(posedge clk) disable iff (rst)
      m_axi_rvalid && !m_axi_rready |=> m_axi_rvalid && $stable(m_axi_rdata)
         && $stable(m_axi_rresp) && $stable(m_axi_rlast))
      else begin
         fail_count++;
         $error("R beat changed before rready");
      end

   rd_ack_after_valid: assert property (@(posedge clk) disable iff (rst)
      rd_ack |-> $past(rd_valid))
      else begin
         fail_count++;
         $error("rd_ack without rd_valid in the cycle before");
      end

   wr_ack_with_valid: assert property (@(posedge clk) disable iff (rst)
      wr_ack |-> wr_valid)
      else begin
         fail_count++;
         $error("wr_ack without wr_valid");
      end

endmodule

bind iob2axi_top iob2axi_chk #(
   .ADDR_W(ADDR_W),
   .DATA_W(DATA_W)
) iob2axi_chk_inst (.*);

//--- test/iob2axi_tb.sv
`timescale 1ns/100ps

module iob2axi_tb import iob2axi_pkg::*; ();

   localparam int ADDR_W = 16;
   localparam int DATA_W = 32;
   localparam int MEM_DEPTH_LOG = 8;
   localparam int DEPTH = 2 ** MEM_DEPTH_LOG;
   localparam int TIMEOUT = 400;

   logic              clk = 1'b0;
   logic              rst;
   axi_len_t          rd_length;
   logic [ADDR_W-1:0] rd_addr;
   logic              rd_valid;
   logic              rd_ready;
   logic              rd_error;
   logic [DATA_W-1:0] rd_data;
   logic              rd_ack;
   axi_len_t          wr_length;
   logic [ADDR_W-1:0] wr_addr;
   logic [DATA_W-1:0] wr_data;
   logic              wr_valid;
   logic              wr_ready;
   logic              wr_error;
   logic              wr_ack;

   logic [31:0]       seed = 32'h416f;
   logic [DATA_W-1:0] model [DEPTH];
   logic [DATA_W-1:0] exp_q [$];

   iob2axi_top #(
      .ADDR_W       (ADDR_W),
      .DATA_W       (DATA_W),
      .MEM_DEPTH_LOG(MEM_DEPTH_LOG)
   ) iob2axi_top_inst (.*);

   always #20 clk = ~clk;

   function automatic logic [31:0] next_rand();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return seed;
   endfunction

   // Upper LCG bits only since the low ones cycle quickly
   function automatic int rand_below(input int n);
      return int'((next_rand() >> 16) % 32'(n));
   endfunction

   function automatic logic [DATA_W-1:0] exp_word(input int idx);
      return (idx < DEPTH) ? model[idx] : '0;
   endfunction

   // Any beat past the end of memory answers slave error
   function automatic logic exp_error(input int start, input int len);
      return (start + len) >= DEPTH;
   endfunction

   task automatic abort_run(input string line);
      $display("%s", line);
      $display("** FAIL **");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_word(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                             input string what);
      if (got !== exp) begin
         abort_run($sformatf("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp));
      end
   endtask

   task automatic check_flag(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         abort_run($sformatf("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp));
      end
   endtask

   task automatic wait_for_ready(input bit write_port);
      int cycles;
      cycles = 0;
      do begin
         @(posedge clk);
         cycles++;
         if (cycles > TIMEOUT) begin
            abort_run(write_port ? "Timed out waiting for wr_ready to return"
                                 : "Timed out waiting for rd_ready to return");
         end
      end while (write_port ? !wr_ready : !rd_ready);
   endtask

   task automatic write_burst(input int start, input int len, input bit stall);
      logic [DATA_W-1:0] words [$];
      int sent;
      int cycles;
      for (int i = 0; i <= len; i++) begin
         words.push_back(next_rand());
      end
      wr_addr <= ADDR_W'(start * (DATA_W / 8));
      wr_length <= axi_len_t'(len);
      wr_data <= words[0];
      wr_valid <= 1'b1;
      sent = 0;
      cycles = 0;
      while (sent <= len) begin
         @(posedge clk);
         cycles++;
         if (cycles > TIMEOUT) begin
            abort_run("Timed out waiting for write burst acks");
         end
         if (wr_ack) begin
            sent++;
            if (sent <= len) begin
               wr_data <= words[sent];
            end
         end
         if (sent > len) begin
            wr_valid <= 1'b0;
         end else if (stall && !wr_ready) begin
            wr_valid <= (rand_below(4) != 0);
         end
      end
      wait_for_ready(1'b1);
      check_flag(wr_error, exp_error(start, len), "wr_error");
      // Out-of-range beats are dropped by the memory
      for (int i = 0; i <= len; i++) begin
         if (start + i < DEPTH) begin
            model[start + i] = words[i];
         end
      end
   endtask

   task automatic read_burst(input int start, input int len, input bit stall);
      int got;
      int cycles;
      for (int i = 0; i <= len; i++) begin
         exp_q.push_back(exp_word(start + i));
      end
      rd_addr <= ADDR_W'(start * (DATA_W / 8));
      rd_length <= axi_len_t'(len);
      rd_valid <= 1'b1;
      got = 0;
      cycles = 0;
      while (got <= len) begin
         @(posedge clk);
         cycles++;
         if (cycles > TIMEOUT) begin
            abort_run("Timed out waiting for read burst acks");
         end
         if (rd_ack) begin
            got++;
         end
         if (got > len) begin
            rd_valid <= 1'b0;
         end else if (stall && !rd_ready) begin
            rd_valid <= (rand_below(4) != 0);
         end
      end
      wait_for_ready(1'b0);
      check_flag(rd_error, exp_error(start, len), "rd_error");
      check_flag(exp_q.size() == 0, 1'b1, "all expected read beats returned");
   endtask

   // Compare every returned read beat in order
   always @(posedge clk) begin
      if (!rst && rd_ack) begin
         if (exp_q.size() == 0) begin
            abort_run("A read beat arrived when none was expected");
         end else begin
            check_word(rd_data, exp_q.pop_front(), "rd_data");
         end
      end
   end

   always @(posedge clk) begin
      if (iob2axi_top_inst.iob2axi_chk_inst.fail_count != 0) begin
         abort_run("A protocol assertion failed");
      end
   end

   initial begin
      int start;
      int len;
      rst = 1'b1;
      rd_length = '0;
      rd_addr = '0;
      rd_valid = 1'b0;
      wr_length = '0;
      wr_addr = '0;
      wr_data = '0;
      wr_valid = 1'b0;
      repeat (10) @(posedge clk);
      rst <= 1'b0;
      @(posedge clk);
      check_flag(rd_ready, 1'b1, "rd_ready after reset");
      check_flag(wr_ready, 1'b1, "wr_ready after reset");
      check_flag(rd_error, 1'b0, "rd_error after reset");
      check_flag(wr_error, 1'b0, "wr_error after reset");
      check_flag(rd_ack, 1'b0, "rd_ack after reset");
      check_flag(wr_ack, 1'b0, "wr_ack after reset");

      // Fill the whole memory so every read has a known value
      for (int b = 0; b < DEPTH / 16; b++) begin
         write_burst(b * 16, 15, 1'b0);
      end

      write_burst(40, 7, 1'b0);
      read_burst(40, 7, 1'b0);
      write_burst(3, 0, 1'b0);
      read_burst(3, 0, 1'b0);

      // Both requests raised together so AR waits behind AW
      fork
         write_burst(64, 5, 1'b0);
         read_burst(128, 5, 1'b0);
      join

      // AW raised while a read burst holds the memory
      fork
         read_burst(160, 7, 1'b0);
         begin
            @(posedge clk);
            write_burst(192, 3, 1'b0);
         end
      join

      for (int n = 0; n < 40; n++) begin
         len = rand_below(16);
         start = rand_below(DEPTH - len);
         write_burst(start, len, 1'b0);
         len = rand_below(16);
         start = rand_below(DEPTH - len);
         read_burst(start, len, 1'b0);
      end

      // Bursts running off the end of memory
      write_burst(DEPTH - 4, 9, 1'b0);
      read_burst(DEPTH - 4, 9, 1'b0);
      read_burst(DEPTH - 2, 5, 1'b0);
      read_burst(0, 15, 1'b0);

      for (int n = 0; n < 10; n++) begin
         len = rand_below(16);
         start = rand_below(DEPTH - len);
         write_burst(start, len, 1'b1);
         read_burst(start, len, 1'b1);
      end

      if (iob2axi_top_inst.iob2axi_chk_inst.fail_count == 0) begin
         $display("** PASS **");
         $finish;
      end else begin
         abort_run("Protocol assertion failures were reported");
      end
   end

endmodule

//--- list.f
hw/iob2axi_pkg.sv
hw/iob2axi_rd.sv
hw/iob2axi_wr.sv
hw/axi_ram.sv
hw/iob2axi_top.sv
test/iob2axi_chk.sv
test/iob2axi_tb.sv

//--- Bender.yml
package:
  name: iob2axi

sources:
  - files:
      - hw/iob2axi_pkg.sv
      - hw/iob2axi_rd.sv
      - hw/iob2axi_wr.sv
      - hw/axi_ram.sv
      - hw/iob2axi_top.sv
  - target: test
    files:
      - test/iob2axi_chk.sv
      - test/iob2axi_tb.sv
